// ==== logic/dmg_clock_pkg.sv ====
// Shared types and timing constants for the clock and reset front end, imported by every block
package dmg_clock_pkg;

	// Machine cycle timing
	localparam int PHASE_COUNT = 4;                   // clk cycles per machine cycle
	localparam int PHASE_WIDTH = $clog2(PHASE_COUNT);

	// Divider and its taps
	localparam int DIV_WIDTH = 16;
	localparam int STABLE_TAP_BIT = 10;               // Short for simulation, real part is slower

	// Divider bit per TAC rate code, entry 0 is code 0
	localparam logic [3:0][3:0] TIMER_TAPS = {4'd7, 4'd5, 4'd3, 4'd9};

	// One-cycle enables that replace the derived clocks
	typedef struct packed {
		logic adr_valid; // Address valid, phase 0
		logic latch;     // Phase 1
		logic data;      // CPU data phase, phase 2
		logic inc;       // Phase 3
		logic main_tick; // 1 MHz tick, with inc
	} clk_strobes_t;

	// Register map of the port
	typedef enum logic [1:0] {
		ADDR_DIV  = 2'd0,
		ADDR_TIMA = 2'd1,
		ADDR_TMA  = 2'd2,
		ADDR_TAC  = 2'd3
	} reg_addr_t;

	// Register access, no read flag since reads are combinational
	typedef struct packed {
		logic       write;
		reg_addr_t  addr;
		logic [7:0] wdata;
	} reg_req_t;

	// Upper TAC bits are unimplemented
	localparam logic [4:0] TAC_UNUSED_BITS = 5'b11111;

endpackage

// ==== logic/clock_phase_gen.sv ====
// Machine-cycle phase sequencer, turns the oscillator and CPU clock enables into strobe pulses
`timescale 1ns/1ps

module clock_phase_gen import dmg_clock_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         osc_ena,
	input  logic         clk_ena,
	output clk_strobes_t strobes
);

	logic [PHASE_WIDTH-1:0] phase;
	logic [PHASE_WIDTH-1:0] phase_next;
	clk_strobes_t           strobes_next;
	logic                   strobe_ena;

	// Phase counter stands in for the four latch divider
	always_comb begin
		if (!osc_ena) begin
			phase_next = '0; // Oscillator stopped
		end else if (phase == PHASE_WIDTH'(PHASE_COUNT - 1)) begin
			phase_next = '0;
		end else begin
			phase_next = phase + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			phase <= '0;
		end else begin
			phase <= phase_next;
		end
	end

	// No pulses without a running oscillator, as the original ck pad stops
	assign strobe_ena = clk_ena & osc_ena;

	// Phase decode
	always_comb begin
		strobes_next = '0;
		if (strobe_ena) begin
			case (phase)
				PHASE_WIDTH'(0): begin
					strobes_next.adr_valid = 1'b1;
				end
				PHASE_WIDTH'(1): begin
					strobes_next.latch = 1'b1;
				end
				PHASE_WIDTH'(2): begin
					strobes_next.data = 1'b1;
				end
				default: begin
					// Last phase, main clock edge of the machine cycle
					strobes_next.inc       = 1'b1;
					strobes_next.main_tick = 1'b1;
				end
			endcase
		end
	end

	// Registered so downstream logic sees clean single-cycle pulses
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			strobes <= '0;
		end else begin
			strobes <= strobes_next;
		end
	end

endmodule

// ==== logic/div_counter.sv ====
// Free-running divider that serves as time base for the timer and the oscillator-stable check
`timescale 1ns/1ps

module div_counter import dmg_clock_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 osc_ena,
	input  reg_req_t             reg_req,
	output logic [DIV_WIDTH-1:0] div_value
);

	logic                 div_clear;
	logic [DIV_WIDTH-1:0] div_next;

	// Any write to DIV resets the whole count, data is ignored
	assign div_clear = reg_req.write && (reg_req.addr == ADDR_DIV);

	always_comb begin
		if (div_clear) begin
			div_next = '0;
		end else if (osc_ena) begin
			div_next = div_value + 1'b1; // One count per oscillator cycle
		end else begin
			div_next = div_value; // Frozen while the crystal is off
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_value <= '0;
		end else begin
			div_value <= div_next;
		end
	end

	// Upper byte is what the CPU sees, lower taps feed the timer

endmodule

// ==== logic/reset_sequencer.sv ====
// Oscillator-stable flag and CPU reset release, aligned to the 1 MHz main tick
`timescale 1ns/1ps

module reset_sequencer import dmg_clock_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 osc_ena,
	input  logic                 main_tick,
	input  logic [DIV_WIDTH-1:0] div_value,
	output logic                 osc_stable,
	output logic                 cpu_reset
);

	logic stable_flag;
	logic stable_tap;
	logic hold_req;

	// Slow divider tap marks the crystal as settled
	assign stable_tap = div_value[STABLE_TAP_BIT];

	// Stable latch, clear has priority over set
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stable_flag <= 1'b0;
		end else if (!osc_ena) begin
			stable_flag <= 1'b0; // Oscillator stopped, must settle again
		end else if (stable_tap) begin
			stable_flag <= 1'b1;
		end
	end

	assign osc_stable = stable_flag;

	// Reset hold-off request while the oscillator is not stable
	assign hold_req = !stable_flag;

	// CPU reset leaves only on a main clock edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cpu_reset <= 1'b1;
		end else if (hold_req) begin
			cpu_reset <= 1'b1; // Re-enter immediately
		end else if (main_tick) begin
			cpu_reset <= 1'b0;
		end
	end

endmodule

// ==== logic/timer_unit.sv ====
// TIMA/TMA/TAC timer counting falling edges of a selected divider tap, with overflow interrupt
`timescale 1ns/1ps

module timer_unit import dmg_clock_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  reg_req_t             reg_req,
	input  logic [DIV_WIDTH-1:0] div_value,
	output logic [7:0]           tima,
	output logic [7:0]           tma,
	output logic [2:0]           tac,
	output logic                 timer_irq
);

	logic [3:0] tap_sel;
	logic       tap_bit;
	logic       tap_prev;
	logic       tap_fall;
	logic       tima_wr;
	logic       tma_wr;
	logic       tac_wr;
	logic       overflow;

	// Register write decode
	assign tima_wr = reg_req.write && (reg_req.addr == ADDR_TIMA);
	assign tma_wr  = reg_req.write && (reg_req.addr == ADDR_TMA);
	assign tac_wr  = reg_req.write && (reg_req.addr == ADDR_TAC);

	// Rate select, TAC bit 2 gates the tap before the edge detector
	assign tap_sel = TIMER_TAPS[tac[1:0]];
	assign tap_bit = div_value[tap_sel] & tac[2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tap_prev <= 1'b0;
		end else begin
			tap_prev <= tap_bit;
		end
	end

	assign tap_fall = tap_prev & ~tap_bit;

	// Overflow only counts if no TIMA write lands in the same cycle
	assign overflow = tap_fall && (tima == 8'hff) && !tima_wr;

	// TIMA counter
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tima <= 8'h00;
		end else if (tima_wr) begin
			tima <= reg_req.wdata; // CPU write wins over the tick
		end else if (overflow) begin
			tima <= tma; // Reload from the modulo
		end else if (tap_fall) begin
			tima <= tima + 8'h01;
		end
	end

	// Modulo and control registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tma <= 8'h00;
			tac <= 3'b000;
		end else begin
			if (tma_wr) begin
				tma <= reg_req.wdata;
			end
			if (tac_wr) begin
				tac <= reg_req.wdata[2:0];
			end
		end
	end

	// One-cycle interrupt request, in step with the reload
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= overflow;
		end
	end

endmodule

// ==== logic/clock_reset_top.sv ====
// Top level of the clock and reset front end, ties the blocks together and serves register reads
`timescale 1ns/1ps

module clock_reset_top import dmg_clock_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         osc_ena,
	input  logic         clk_ena,
	input  reg_req_t     reg_req,
	output clk_strobes_t strobes,
	output logic         osc_stable,
	output logic         cpu_reset,
	output logic [7:0]   rdata,
	output logic         timer_irq
);

	logic [DIV_WIDTH-1:0] div_value;
	logic [7:0]           tima;
	logic [7:0]           tma;
	logic [2:0]           tac;

	clock_phase_gen i_clock_phase_gen (
		.clk     (clk),
		.rst_n   (rst_n),
		.osc_ena (osc_ena),
		.clk_ena (clk_ena),
		.strobes (strobes)
	);

	div_counter i_div_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.osc_ena   (osc_ena),
		.reg_req   (reg_req),
		.div_value (div_value)
	);

	reset_sequencer i_reset_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.osc_ena    (osc_ena),
		.main_tick  (strobes.main_tick),
		.div_value  (div_value),
		.osc_stable (osc_stable),
		.cpu_reset  (cpu_reset)
	);

	timer_unit i_timer_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.reg_req   (reg_req),
		.div_value (div_value),
		.tima      (tima),
		.tma       (tma),
		.tac       (tac),
		.timer_irq (timer_irq)
	);

	// Read data mux
	always_comb begin
		case (reg_req.addr)
			ADDR_DIV:  rdata = div_value[DIV_WIDTH-1 -: 8]; // Only the upper byte is visible
			ADDR_TIMA: rdata = tima;
			ADDR_TMA:  rdata = tma;
			default:   rdata = {TAC_UNUSED_BITS, tac};
		endcase
	end

endmodule

// ==== testbench/clock_reset_properties.sv ====
// Concurrent checks on strobes and the timer interrupt, attached to the top level with bind
`timescale 1ns/1ps

module clock_reset_properties import dmg_clock_pkg::*; (
	input logic         clk,
	input logic         rst_n,
	input logic         osc_ena,
	input clk_strobes_t strobes,
	input logic         timer_irq
);

	int fail_count = 0; // Read by the testbench at the end of the run

	// Address, latch and data phases never overlap
	phase_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({strobes.adr_valid, strobes.latch, strobes.data}))
	else begin
		fail_count++;
		$error("More than one of adr_valid, latch and data high in one cycle");
	end

	// Main tick is the last phase
	tick_with_inc: assert property (@(posedge clk) disable iff (!rst_n)
		strobes.main_tick |-> strobes.inc)
	else begin
		fail_count++;
		$error("main_tick seen without inc");
	end

	no_strobe_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(osc_ena) |-> (strobes == '0))
	else begin
		fail_count++;
		$error("Strobe high after a cycle with the oscillator stopped");
	end

	irq_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		timer_irq |=> !timer_irq)
	else begin
		fail_count++;
		$error("timer_irq held for two cycles");
	end

endmodule

bind clock_reset_top clock_reset_properties i_clock_reset_properties (
	.clk       (clk),
	.rst_n     (rst_n),
	.osc_ena   (osc_ena),
	.strobes   (strobes),
	.timer_irq (timer_irq)
);

// ==== testbench/tb_clock_reset.sv ====
// Testbench for the clock and reset front end, random register traffic against a cycle model
`timescale 1ns/1ps

module tb_clock_reset import dmg_clock_pkg::*; ();

	logic         clk;
	logic         rst_n;
	logic         osc_ena;
	logic         clk_ena;
	reg_req_t     reg_req;
	clk_strobes_t strobes;
	logic         osc_stable;
	logic         cpu_reset;
	logic [7:0]   rdata;
	logic         timer_irq;

	// Reference model state
	logic [1:0]   m_phase;
	clk_strobes_t m_strobes;
	logic [15:0]  m_div;
	logic         m_stable;
	logic         m_cpu_reset;
	logic [7:0]   m_tima;
	logic [7:0]   m_tma;
	logic [2:0]   m_tac;
	logic         m_tap_prev;
	logic         m_irq;

	int          errors;
	int          timeouts;
	int          checks;
	int          irq_count;
	int          assert_fails;
	bit          checking;
	int unsigned seed_val;

	clock_reset_top i_clock_reset_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.osc_ena    (osc_ena),
		.clk_ena    (clk_ena),
		.reg_req    (reg_req),
		.strobes    (strobes),
		.osc_stable (osc_stable),
		.cpu_reset  (cpu_reset),
		.rdata      (rdata),
		.timer_irq  (timer_irq)
	);

	always #4 clk = ~clk;

	// Divider bit for each TAC rate code
	function automatic int tap_for_rate(input logic [1:0] code);
		case (code)
			2'd0:    return 9;
			2'd1:    return 3;
			2'd2:    return 5;
			default: return 7;
		endcase
	endfunction

	function automatic logic model_tap();
		return m_div[tap_for_rate(m_tac[1:0])] & m_tac[2];
	endfunction

	function automatic logic [7:0] expected_rdata();
		case (reg_req.addr)
			ADDR_DIV:  return m_div[15:8];
			ADDR_TIMA: return m_tima;
			ADDR_TMA:  return m_tma;
			default:   return {5'b11111, m_tac}; // Unused TAC bits read high
		endcase
	endfunction

	// Cycle model updated in dependency order so each rule sees the old state
	always @(posedge clk) begin
		logic tap_now;
		logic fall;
		logic tima_wr;
		logic ovf;
		if (!rst_n) begin
			m_phase = '0;
			m_strobes = '0;
			m_div = '0;
			m_stable = 1'b0;
			m_cpu_reset = 1'b1;
			m_tima = '0;
			m_tma = '0;
			m_tac = '0;
			m_tap_prev = 1'b0;
			m_irq = 1'b0;
		end else begin
			tap_now = model_tap();
			fall = m_tap_prev & ~tap_now;
			tima_wr = reg_req.write && (reg_req.addr == ADDR_TIMA);
			ovf = fall && (m_tima == 8'hff) && !tima_wr;
			if (!m_stable) m_cpu_reset = 1'b1;
			else if (m_strobes.main_tick) m_cpu_reset = 1'b0;
			if (!osc_ena) m_stable = 1'b0;
			else if (m_div[STABLE_TAP_BIT]) m_stable = 1'b1;
			m_strobes = '0;
			if (clk_ena && osc_ena) begin
				case (m_phase)
					2'd0: m_strobes.adr_valid = 1'b1;
					2'd1: m_strobes.latch = 1'b1;
					2'd2: m_strobes.data = 1'b1;
					default: begin
						m_strobes.inc = 1'b1;
						m_strobes.main_tick = 1'b1;
					end
				endcase
			end
			m_phase = osc_ena ? m_phase + 2'd1 : 2'd0;
			if (reg_req.write && reg_req.addr == ADDR_DIV) m_div = '0;
			else if (osc_ena) m_div = m_div + 16'd1;
			if (tima_wr) m_tima = reg_req.wdata;
			else if (ovf) m_tima = m_tma;
			else if (fall) m_tima = m_tima + 8'd1;
			if (reg_req.write && reg_req.addr == ADDR_TMA) m_tma = reg_req.wdata;
			if (reg_req.write && reg_req.addr == ADDR_TAC) m_tac = reg_req.wdata[2:0];
			m_tap_prev = tap_now;
			m_irq = ovf;
		end
	end

	task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// Outputs are compared mid-cycle
	always @(negedge clk) begin
		if (checking) begin
			check_value("strobes", strobes, m_strobes);
			check_value("osc_stable", osc_stable, m_stable);
			check_value("cpu_reset", cpu_reset, m_cpu_reset);
			check_value("timer_irq", timer_irq, m_irq);
			check_value("rdata", rdata, expected_rdata());
			if (timer_irq === 1'b1) irq_count++;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
		reg_req.write = 1'b1;
		reg_req.addr = addr;
		reg_req.wdata = data;
		next_cycle();
		reg_req.write = 1'b0;
	endtask

	function automatic bit condition_met(input int which);
		case (which)
			0:       return osc_stable === 1'b1;
			1:       return cpu_reset === 1'b0;
			2:       return timer_irq === 1'b1;
			default: return m_tap_prev && !model_tap(); // Timer tick at the coming edge
		endcase
	endfunction

	task automatic await_condition(input int which, input int limit, input string what);
		int n;
		n = 0;
		while (!condition_met(which) && n < limit) begin
			next_cycle();
			n++;
		end
		if (!condition_met(which)) begin
			timeouts++;
			$display("Timeout: %s did not happen within %0d cycles", what, limit);
		end
	endtask

	task automatic random_cycle();
		int unsigned r;
		reg_addr_t   addr;
		logic [7:0]  data;
		r = $urandom_range(0, 999);
		if (osc_ena && r < 4) osc_ena = 1'b0;
		else if (!osc_ena && r < 150) osc_ena = 1'b1;
		if ($urandom_range(0, 15) == 0) clk_ena = ~clk_ena;
		addr = reg_addr_t'($urandom_range(0, 3));
		data = 8'($urandom);
		reg_req.write = 1'b0;
		if ($urandom_range(0, 9) >= 7) begin
			if (addr == ADDR_DIV && $urandom_range(0, 15) != 0) addr = ADDR_TIMA; // Rare DIV clears
			if (addr == ADDR_TAC && $urandom_range(0, 3) != 0) begin
				data[2:0] = {1'b1, 2'($urandom_range(1, 3))}; // Enabled at a fast rate
			end
			reg_req.write = 1'b1;
		end
		reg_req.addr = addr;
		reg_req.wdata = data;
		next_cycle();
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		osc_ena = 1'b0;
		clk_ena = 1'b0;
		reg_req = '0;
		errors = 0;
		timeouts = 0;
		checks = 0;
		irq_count = 0;
		checking = 1'b0;
		seed_val = $urandom(72437);
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		osc_ena = 1'b1;
		clk_ena = 1'b1;
		checking = 1'b1;

		await_condition(0, 3000, "osc_stable after reset");
		await_condition(1, 40, "cpu_reset release");

		// DIV clear with an arbitrary value and read back
		repeat (20) next_cycle();
		write_reg(ADDR_DIV, 8'($urandom));
		reg_req.addr = ADDR_DIV;
		repeat (300) next_cycle();

		// Overflow reload and interrupt on the fastest tap
		write_reg(ADDR_TMA, 8'hf0);
		write_reg(ADDR_TIMA, 8'hfd);
		write_reg(ADDR_TAC, {5'($urandom), 3'b101});
		reg_req.addr = ADDR_TIMA; // Count and reload seen on the read port
		await_condition(2, 400, "timer_irq on overflow");
		await_condition(3, 200, "timer tick");
		write_reg(ADDR_TIMA, 8'h42); // Lands on the tick edge
		reg_req.addr = ADDR_TIMA;
		repeat (10) next_cycle();

		// Oscillator stop and restart
		osc_ena = 1'b0;
		repeat (10) next_cycle();
		osc_ena = 1'b1;
		await_condition(0, 2500, "osc_stable after oscillator restart");
		await_condition(1, 40, "cpu_reset release after restart");

		repeat (4000) random_cycle();
		reg_req.write = 1'b0;
		repeat (8) next_cycle();
		checking = 1'b0;

		assert_fails = i_clock_reset_top.i_clock_reset_properties.fail_count;
		$display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d, irq pulses %0d",
			checks, errors, timeouts, assert_fails, irq_count);
		if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== files.f ====
logic/dmg_clock_pkg.sv
logic/clock_phase_gen.sv
logic/div_counter.sv
logic/reset_sequencer.sv
logic/timer_unit.sv
logic/clock_reset_top.sv
testbench/clock_reset_properties.sv
testbench/tb_clock_reset.sv

// ==== Bender.yml ====
package:
  name: dmg_clock_reset

sources:
  # Design sources, package first
  - files:
      - logic/dmg_clock_pkg.sv
      - logic/clock_phase_gen.sv
      - logic/div_counter.sv
      - logic/reset_sequencer.sv
      - logic/timer_unit.sv
      - logic/clock_reset_top.sv

  # Verification sources
  - target: test
    files:
      - testbench/clock_reset_properties.sv
      - testbench/tb_clock_reset.sv
